// File: logic/issue_pkg.sv
`default_nettype none

package issue_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  tag_t;     // Tag zero means the value is present.

    localparam int NUM_REGS       = 32;
    localparam int FUNCT7_ALT_BIT = 5;  // Selects sub and sra.

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    typedef enum logic [2:0] {
        add  = 3'b000,
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101,
        aor  = 3'b110,
        aand = 3'b111
    } arith_funct3_t;

    // The shared codes match funct3 so most operations pass straight through.
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_t;

    typedef enum logic [2:0] {
        cmp_blt  = 3'b100,
        cmp_bltu = 3'b110
    } cmp_op_t;

    typedef enum logic [1:0] {
        rob_reg  = 2'b00,
        rob_st   = 2'b01,
        rob_br   = 2'b10,
        rob_jalr = 2'b11
    } rob_op_t;

endpackage

`default_nettype wire

// File: logic/queue_if.sv
`default_nettype none
`timescale 1ns/1ns

interface queue_if;
    import issue_pkg::*;

    logic  head_valid;
    word_t head_pc;
    word_t head_inst;
    logic  shift;       // Pops the head at the next edge.

    modport queue (
        output head_valid,
        output head_pc,
        output head_inst,
        input  shift
    );

    modport decoder (
        input  head_valid,
        input  head_pc,
        input  head_inst,
        output shift
    );

endinterface

`default_nettype wire

// File: logic/operand_if.sv
`default_nettype none
`timescale 1ns/1ns

interface operand_if;
    import issue_pkg::*;

    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     load_tag;
    tag_t     new_tag;
    reg_idx_t rd;

    // Read results, with any bus result of this cycle already merged in.
    tag_t     qj;
    tag_t     qk;
    word_t    vj;
    word_t    vk;

    modport decoder (
        output rs1,
        output rs2,
        output load_tag,
        output new_tag,
        output rd,
        input  qj,
        input  qk,
        input  vj,
        input  vk
    );

    modport status (
        input  rs1,
        input  rs2,
        input  load_tag,
        input  new_tag,
        input  rd,
        output qj,
        output qk,
        output vj,
        output vk
    );

endinterface

`default_nettype wire

// File: logic/inst_queue.sv
`default_nettype none
`timescale 1ns/1ns

module inst_queue #(
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_valid,
    input  issue_pkg::word_t i_pc,
    input  issue_pkg::word_t i_inst,
    output logic             o_ready,
    queue_if.queue           q
);
    import issue_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR   = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(DEPTH);

    word_t            pc_mem   [DEPTH];
    word_t            inst_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             wr_en;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
    endfunction

    assign full         = (count == FULL_COUNT);
    assign o_ready      = !full;
    assign wr_en        = i_valid && !full;
    assign q.head_valid = (count != '0);
    assign q.head_pc    = pc_mem[rd_ptr];
    assign q.head_inst  = inst_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            pc_mem[wr_ptr]   <= i_pc;
            inst_mem[wr_ptr] <= i_inst;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= next_ptr(wr_ptr);
            if (q.shift) rd_ptr <= next_ptr(rd_ptr);
            case ({wr_en, q.shift})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The count never passes the depth, so no write lands on a full queue.
    assert property (@(posedge clk) disable iff (rst) count <= FULL_COUNT);

    // The decoder may only pop an entry that is there.
    assert property (@(posedge clk) disable iff (rst) q.shift |-> q.head_valid);

endmodule

`default_nettype wire

// File: logic/reg_status.sv
`default_nettype none
`timescale 1ns/1ns

module reg_status (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_cdb_valid,
    input  issue_pkg::tag_t  i_cdb_tag,
    input  issue_pkg::word_t i_cdb_value,
    operand_if.status        ops
);
    import issue_pkg::*;

    word_t values [NUM_REGS];
    tag_t  tags   [NUM_REGS];   // Nonzero while a result is still on its way.

    // True when the bus carries the result this register is waiting for.
    function automatic logic cdb_hit(reg_idx_t idx);
        return i_cdb_valid && (tags[idx] != '0) && (tags[idx] == i_cdb_tag);
    endfunction

    function automatic tag_t src_tag(reg_idx_t idx);
        if (idx == '0 || cdb_hit(idx)) begin
            return '0;
        end
        return tags[idx];
    endfunction

    function automatic word_t src_value(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (cdb_hit(idx)) begin
            return i_cdb_value;     // Bypass the result written at this edge.
        end
        return values[idx];
    endfunction

    always_comb begin
        ops.qj = src_tag(ops.rs1);
        ops.qk = src_tag(ops.rs2);
        ops.vj = src_value(ops.rs1);
        ops.vk = src_value(ops.rs2);
    end

    // Register zero is never written, so it keeps its reset state.
    always_ff @(posedge clk) begin
        if (rst) begin
            values <= '{default: '0};
            tags   <= '{default: '0};
        end else begin
            for (int i = 1; i < NUM_REGS; i++) begin
                if (ops.load_tag && ops.rd == reg_idx_t'(i)) begin
                    // A newer producer takes over even if the old result lands now.
                    tags[i] <= ops.new_tag;
                end else if (cdb_hit(reg_idx_t'(i))) begin
                    values[i] <= i_cdb_value;
                    tags[i]   <= '0;
                end
            end
        end
    end

    // The decoder discards writes to x0 and must never claim it.
    assert property (@(posedge clk) disable iff (rst) ops.load_tag |-> ops.rd != '0);

endmodule

`default_nettype wire

// File: logic/issue_decoder.sv
`default_nettype none
`timescale 1ns/1ns

module issue_decoder (
    input  logic                clk,
    input  logic                rst,
    queue_if.decoder            q,
    operand_if.decoder          ops,
    input  issue_pkg::tag_t     i_free_tag,
    input  logic                i_alu_ready,
    input  logic                i_cmp_ready,
    output logic                o_alu_valid,
    output issue_pkg::alu_op_t  o_alu_op,
    output issue_pkg::word_t    o_alu_vj,
    output issue_pkg::word_t    o_alu_vk,
    output issue_pkg::tag_t     o_alu_qj,
    output issue_pkg::tag_t     o_alu_qk,
    output issue_pkg::tag_t     o_alu_dest,
    output logic                o_cmp_valid,
    output issue_pkg::cmp_op_t  o_cmp_op,
    output issue_pkg::word_t    o_cmp_vj,
    output issue_pkg::word_t    o_cmp_vk,
    output issue_pkg::tag_t     o_cmp_qj,
    output issue_pkg::tag_t     o_cmp_qk,
    output issue_pkg::tag_t     o_cmp_dest,
    output logic                o_rob_valid,
    output issue_pkg::rob_op_t  o_rob_op,
    output issue_pkg::word_t    o_rob_dest
);
    import issue_pkg::*;

    opcode_t       opcode;
    arith_funct3_t funct3;
    logic [6:0]    funct7;
    reg_idx_t      rd;
    word_t         i_imm;
    word_t         u_imm;
    logic          alt;
    logic          supported;
    logic          to_cmp;
    logic          issue;
    alu_op_t       alu_op;
    cmp_op_t       cmp_op;
    word_t         vj;
    word_t         vk;
    tag_t          qj;
    tag_t          qk;

    assign opcode  = opcode_t'(q.head_inst[6:0]);
    assign funct3  = arith_funct3_t'(q.head_inst[14:12]);
    assign funct7  = q.head_inst[31:25];
    assign rd      = q.head_inst[11:7];
    assign i_imm   = {{20{q.head_inst[31]}}, q.head_inst[31:20]};
    assign u_imm   = {q.head_inst[31:12], 12'h000};
    assign alt     = funct7[FUNCT7_ALT_BIT];
    assign ops.rs1 = q.head_inst[19:15];
    assign ops.rs2 = q.head_inst[24:20];

    // Operation, station and operands for the head instruction.
    always_comb begin
        supported = 1'b1;
        to_cmp    = 1'b0;
        alu_op    = alu_add;
        cmp_op    = cmp_blt;
        vj        = ops.vj;
        qj        = ops.qj;
        vk        = ops.vk;
        qk        = ops.qk;
        case (opcode)
            op_imm, op_reg: begin
                if (opcode == op_imm) begin
                    vk = i_imm;
                    qk = '0;
                end
                case (funct3)
                    slt, sltu: begin
                        to_cmp = 1'b1;
                        cmp_op = (funct3 == sltu) ? cmp_bltu : cmp_blt;
                    end
                    sr:      alu_op = alt ? alu_sra : alu_srl;
                    add:     alu_op = (opcode == op_reg && alt) ? alu_sub : alu_add;
                    default: alu_op = alu_op_t'(funct3);
                endcase
            end
            op_lui, op_auipc: begin
                vj = (opcode == op_auipc) ? q.head_pc : '0;
                qj = '0;
                vk = u_imm;
                qk = '0;
            end
            default: supported = 1'b0;
        endcase
    end

    // The single issue decision; everything below follows from it.
    always_comb begin
        issue = q.head_valid && supported && rd != '0 && i_free_tag != '0 &&
                (to_cmp ? i_cmp_ready : i_alu_ready);
        q.shift      = issue || (q.head_valid && (!supported || rd == '0));
        ops.load_tag = issue;
        ops.new_tag  = i_free_tag;
        ops.rd       = rd;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_alu_valid <= 1'b0;
            o_cmp_valid <= 1'b0;
            o_rob_valid <= 1'b0;
        end else begin
            o_alu_valid <= issue && !to_cmp;
            o_cmp_valid <= issue && to_cmp;
            o_rob_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue && !to_cmp) begin
            o_alu_op   <= alu_op;
            o_alu_vj   <= vj;
            o_alu_vk   <= vk;
            o_alu_qj   <= qj;
            o_alu_qk   <= qk;
            o_alu_dest <= i_free_tag;
        end
        if (issue && to_cmp) begin
            o_cmp_op   <= cmp_op;
            o_cmp_vj   <= vj;
            o_cmp_vk   <= vk;
            o_cmp_qj   <= qj;
            o_cmp_qk   <= qk;
            o_cmp_dest <= i_free_tag;
        end
        if (issue) begin
            o_rob_op   <= rob_reg;
            o_rob_dest <= word_t'(rd);  // The ROB retires into this register.
        end
    end

    // Each instruction goes to one station only.
    assert property (@(posedge clk) disable iff (rst) !(o_alu_valid && o_cmp_valid));

endmodule

`default_nettype wire

// File: logic/issue_unit.sv
`default_nettype none
`timescale 1ns/1ns

module issue_unit #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_inst_valid,
    input  issue_pkg::word_t   i_pc,
    input  issue_pkg::word_t   i_inst,
    output logic               o_inst_ready,
    input  issue_pkg::tag_t    i_free_tag,
    input  logic               i_cdb_valid,
    input  issue_pkg::tag_t    i_cdb_tag,
    input  issue_pkg::word_t   i_cdb_value,
    input  logic               i_alu_ready,
    output logic               o_alu_valid,
    output issue_pkg::alu_op_t o_alu_op,
    output issue_pkg::word_t   o_alu_vj,
    output issue_pkg::word_t   o_alu_vk,
    output issue_pkg::tag_t    o_alu_qj,
    output issue_pkg::tag_t    o_alu_qk,
    output issue_pkg::tag_t    o_alu_dest,
    input  logic               i_cmp_ready,
    output logic               o_cmp_valid,
    output issue_pkg::cmp_op_t o_cmp_op,
    output issue_pkg::word_t   o_cmp_vj,
    output issue_pkg::word_t   o_cmp_vk,
    output issue_pkg::tag_t    o_cmp_qj,
    output issue_pkg::tag_t    o_cmp_qk,
    output issue_pkg::tag_t    o_cmp_dest,
    output logic               o_rob_valid,
    output issue_pkg::rob_op_t o_rob_op,
    output issue_pkg::word_t   o_rob_dest
);

    queue_if   u_queue_if ();
    operand_if u_operand_if ();

    inst_queue #(
        .DEPTH (QUEUE_DEPTH)
    ) u_inst_queue (
        .clk     (clk),
        .rst     (rst),
        .i_valid (i_inst_valid),
        .i_pc    (i_pc),
        .i_inst  (i_inst),
        .o_ready (o_inst_ready),
        .q       (u_queue_if.queue)
    );

    reg_status u_reg_status (
        .clk         (clk),
        .rst         (rst),
        .i_cdb_valid (i_cdb_valid),
        .i_cdb_tag   (i_cdb_tag),
        .i_cdb_value (i_cdb_value),
        .ops         (u_operand_if.status)
    );

    issue_decoder u_issue_decoder (
        .clk         (clk),
        .rst         (rst),
        .q           (u_queue_if.decoder),
        .ops         (u_operand_if.decoder),
        .i_free_tag  (i_free_tag),
        .i_alu_ready (i_alu_ready),
        .i_cmp_ready (i_cmp_ready),
        .o_alu_valid (o_alu_valid),
        .o_alu_op    (o_alu_op),
        .o_alu_vj    (o_alu_vj),
        .o_alu_vk    (o_alu_vk),
        .o_alu_qj    (o_alu_qj),
        .o_alu_qk    (o_alu_qk),
        .o_alu_dest  (o_alu_dest),
        .o_cmp_valid (o_cmp_valid),
        .o_cmp_op    (o_cmp_op),
        .o_cmp_vj    (o_cmp_vj),
        .o_cmp_vk    (o_cmp_vk),
        .o_cmp_qj    (o_cmp_qj),
        .o_cmp_qk    (o_cmp_qk),
        .o_cmp_dest  (o_cmp_dest),
        .o_rob_valid (o_rob_valid),
        .o_rob_op    (o_rob_op),
        .o_rob_dest  (o_rob_dest)
    );

endmodule

`default_nettype wire

// File: test/tb_issue_unit.sv
`default_nettype none
`timescale 1ns/1ns

module tb_issue_unit;
    import issue_pkg::*;

    localparam int     CLK_PERIOD  = 40;
    localparam int     SEED        = 77972;
    localparam int     N_ALU       = 40;
    localparam int     N_CMP       = 24;
    localparam int     N_UPPER     = 16;
    localparam int     N_DEPS      = 40;
    localparam int     N_RDZERO    = 30;
    localparam int     N_STRESS    = 150;
    localparam int     TOTAL_INSTS = N_ALU + N_CMP + N_UPPER + N_DEPS + N_RDZERO + N_STRESS;
    localparam longint WATCHDOG_NS = longint'(TOTAL_INSTS * 20 + 200) * CLK_PERIOD;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_t;

    typedef struct packed {
        word_t v;
        tag_t  t;
    } operand_t;

    typedef struct packed {
        logic     to_cmp;
        alu_op_t  alu_op;
        cmp_op_t  cmp_op;
        word_t    vj;
        word_t    vk;
        tag_t     qj;
        tag_t     qk;
        reg_idx_t rd;
    } dispatch_t;

    logic    clk;
    logic    rst;
    logic    i_inst_valid;
    word_t   i_pc;
    word_t   i_inst;
    logic    o_inst_ready;
    tag_t    i_free_tag;
    logic    i_cdb_valid;
    tag_t    i_cdb_tag;
    word_t   i_cdb_value;
    logic    i_alu_ready;
    logic    o_alu_valid;
    alu_op_t o_alu_op;
    word_t   o_alu_vj;
    word_t   o_alu_vk;
    tag_t    o_alu_qj;
    tag_t    o_alu_qk;
    tag_t    o_alu_dest;
    logic    i_cmp_ready;
    logic    o_cmp_valid;
    cmp_op_t o_cmp_op;
    word_t   o_cmp_vj;
    word_t   o_cmp_vk;
    tag_t    o_cmp_qj;
    tag_t    o_cmp_qk;
    tag_t    o_cmp_dest;
    logic    o_rob_valid;
    rob_op_t o_rob_op;
    word_t   o_rob_dest;

    // Model of the register table, plus the ROB tags that are still in flight.
    word_t    model_val [NUM_REGS];
    tag_t     model_tag [NUM_REGS];
    bit       in_use    [16];
    fetch_t   fetched   [$];        // Accepted instructions in program order.
    logic     prev_cdb_valid;
    tag_t     prev_cdb_tag;
    word_t    prev_cdb_value;
    tag_t     prev_free_tag;
    reg_idx_t issued_rd;
    tag_t     issued_tag;
    tag_t     last_offered;
    int       rot;
    logic     stress;
    word_t    next_pc;
    int       errors;
    int       sent;
    int       dispatched;
    int       discarded;
    int       pending_reads;
    int       test_issued;
    int       tests_run;

    issue_unit #(
        .QUEUE_DEPTH (4)
    ) u_issue_unit (
        .clk          (clk),
        .rst          (rst),
        .i_inst_valid (i_inst_valid),
        .i_pc         (i_pc),
        .i_inst       (i_inst),
        .o_inst_ready (o_inst_ready),
        .i_free_tag   (i_free_tag),
        .i_cdb_valid  (i_cdb_valid),
        .i_cdb_tag    (i_cdb_tag),
        .i_cdb_value  (i_cdb_value),
        .i_alu_ready  (i_alu_ready),
        .o_alu_valid  (o_alu_valid),
        .o_alu_op     (o_alu_op),
        .o_alu_vj     (o_alu_vj),
        .o_alu_vk     (o_alu_vk),
        .o_alu_qj     (o_alu_qj),
        .o_alu_qk     (o_alu_qk),
        .o_alu_dest   (o_alu_dest),
        .i_cmp_ready  (i_cmp_ready),
        .o_cmp_valid  (o_cmp_valid),
        .o_cmp_op     (o_cmp_op),
        .o_cmp_vj     (o_cmp_vj),
        .o_cmp_vk     (o_cmp_vk),
        .o_cmp_qj     (o_cmp_qj),
        .o_cmp_qk     (o_cmp_qk),
        .o_cmp_dest   (o_cmp_dest),
        .o_rob_valid  (o_rob_valid),
        .o_rob_op     (o_rob_op),
        .o_rob_dest   (o_rob_dest)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // A source reads as a value with tag zero, or as the tag of its producer.
    function automatic operand_t read_source(
        input reg_idx_t idx,
        input word_t    vals [NUM_REGS],
        input tag_t     tgs  [NUM_REGS],
        input logic     bus_valid,
        input tag_t     bus_tag,
        input word_t    bus_value
    );
        operand_t src;
        src.v = vals[idx];
        src.t = tgs[idx];
        if (idx == '0) begin
            src = '0;
        end else if (bus_valid && tgs[idx] != '0 && tgs[idx] == bus_tag) begin
            src.v = bus_value;  // The result lands in the same cycle.
            src.t = '0;
        end
        return src;
    endfunction

    function automatic dispatch_t predict_dispatch(
        input word_t inst,
        input word_t pc,
        input word_t vals [NUM_REGS],
        input tag_t  tgs  [NUM_REGS],
        input logic  bus_valid,
        input tag_t  bus_tag,
        input word_t bus_value
    );
        dispatch_t  d;
        operand_t   src;
        logic [6:0] opc;
        logic [2:0] f3;
        logic       alt;
        opc      = inst[6:0];
        f3       = inst[14:12];
        alt      = inst[25 + FUNCT7_ALT_BIT];
        d        = '0;
        d.alu_op = alu_add;
        d.cmp_op = cmp_blt;
        d.rd     = inst[11:7];
        if (opc == op_lui || opc == op_auipc) begin
            d.vj = (opc == op_auipc) ? pc : '0;
            d.vk = {inst[31:12], 12'h000};
            return d;
        end
        src  = read_source(inst[19:15], vals, tgs, bus_valid, bus_tag, bus_value);
        d.vj = src.v;
        d.qj = src.t;
        if (opc == op_imm) begin
            d.vk = {{20{inst[31]}}, inst[31:20]};
        end else begin
            src  = read_source(inst[24:20], vals, tgs, bus_valid, bus_tag, bus_value);
            d.vk = src.v;
            d.qk = src.t;
        end
        case (f3)
            3'd2: begin
                d.to_cmp = 1'b1;
                d.cmp_op = cmp_blt;
            end
            3'd3: begin
                d.to_cmp = 1'b1;
                d.cmp_op = cmp_bltu;
            end
            3'd0:    d.alu_op = (opc == op_reg && alt) ? alu_sub : alu_add;
            3'd1:    d.alu_op = alu_sll;
            3'd4:    d.alu_op = alu_xor;
            3'd5:    d.alu_op = alt ? alu_sra : alu_srl;
            3'd6:    d.alu_op = alu_or;
            default: d.alu_op = alu_and;
        endcase
        return d;
    endfunction

    // Kind 0 makes ALU operations, 1 compares, 2 upper immediates and 3 dense dependencies.
    // Kinds 4 and 5 mix all of them and sometimes write x0.
    function automatic word_t gen_inst(input int kind);
        int          cls;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [6:0]  opc;
        cls = (kind < 3) ? kind : int'($urandom % 3);
        rd  = reg_idx_t'(1 + $urandom % 31);
        rs1 = reg_idx_t'($urandom % 32);
        rs2 = reg_idx_t'($urandom % 32);
        if (kind == 3) begin
            rd  = reg_idx_t'(1 + $urandom % 3);
            rs1 = reg_idx_t'($urandom % 4);
            rs2 = reg_idx_t'($urandom % 4);
        end
        if (kind >= 4 && $urandom % 4 == 0) rd = '0;
        if (cls == 2) begin
            opc = ($urandom % 2 == 0) ? op_lui : op_auipc;
            return {20'($urandom), rd, opc};
        end
        alt = 1'($urandom % 2);
        if (cls == 1) begin
            f3 = 3'd2 + 3'($urandom % 2);
        end else begin
            case ($urandom % 6)
                0:       f3 = 3'd0;
                1:       f3 = 3'd1;
                2:       f3 = 3'd4;
                3:       f3 = 3'd5;
                4:       f3 = 3'd6;
                default: f3 = 3'd7;
            endcase
        end
        imm = 12'($urandom);
        if (f3 == 3'd1 || f3 == 3'd5) imm = {1'b0, alt && f3 == 3'd5, 5'b0, imm[4:0]};
        if ($urandom % 2 == 0) begin
            opc = op_imm;
            return {imm, rs1, f3, rd, opc};
        end
        opc = op_reg;
        return {1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'b0, rs2, rs1, f3, rd, opc};
    endfunction

    task automatic compare_alu(input string name, input alu_op_t want, input alu_op_t got);
        if (got !== want) begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, want, got);
            errors++;
        end
    endtask

    task automatic compare_cmp(input string name, input cmp_op_t want, input cmp_op_t got);
        if (got !== want) begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, want, got);
            errors++;
        end
    endtask

    task automatic compare_rob(input string name, input rob_op_t want, input rob_op_t got);
        if (got !== want) begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, want, got);
            errors++;
        end
    endtask

    task automatic compare_word(input string name, input word_t want, input word_t got);
        if (got !== want) begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, want, got);
            errors++;
        end
    endtask

    task automatic compare_tag(input string name, input tag_t want, input tag_t got);
        if (got !== want) begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, want, got);
            errors++;
        end
    endtask

    task automatic compare_operands(input string stn, input dispatch_t want, input word_t vj,
                                    input word_t vk, input tag_t qj, input tag_t qk,
                                    input tag_t dest);
        compare_tag({stn, "_qj"}, want.qj, qj);
        compare_tag({stn, "_qk"}, want.qk, qk);
        // Pending sources carry no value.
        if (want.qj == '0) compare_word({stn, "_vj"}, want.vj, vj);
        if (want.qk == '0) compare_word({stn, "_vk"}, want.vk, vk);
        compare_tag({stn, "_dest"}, prev_free_tag, dest);
    endtask

    // Matches a dispatch pulse with the oldest instruction that is not discarded.
    task automatic check_dispatch();
        fetch_t    ent;
        dispatch_t want;
        while (fetched.size() > 0 && fetched[0].inst[11:7] == '0) begin
            void'(fetched.pop_front());
        end
        if (fetched.size() == 0) begin
            $display("[ERROR] t=%0t a dispatch appeared with no instruction waiting", $time);
            errors++;
            return;
        end
        ent  = fetched.pop_front();
        want = predict_dispatch(ent.inst, ent.pc, model_val, model_tag,
                                prev_cdb_valid, prev_cdb_tag, prev_cdb_value);
        if (want.to_cmp && !(o_cmp_valid && !o_alu_valid)) begin
            $display("[ERROR] t=%0t instruction %h did not go to the compare port alone",
                     $time, ent.inst);
            errors++;
        end else if (!want.to_cmp && !(o_alu_valid && !o_cmp_valid)) begin
            $display("[ERROR] t=%0t instruction %h did not go to the ALU port alone",
                     $time, ent.inst);
            errors++;
        end else if (want.to_cmp) begin
            compare_cmp("o_cmp_op", want.cmp_op, o_cmp_op);
            compare_operands("o_cmp", want, o_cmp_vj, o_cmp_vk, o_cmp_qj, o_cmp_qk, o_cmp_dest);
        end else begin
            compare_alu("o_alu_op", want.alu_op, o_alu_op);
            compare_operands("o_alu", want, o_alu_vj, o_alu_vk, o_alu_qj, o_alu_qk, o_alu_dest);
        end
        if (!o_rob_valid) begin
            $display("[ERROR] t=%0t instruction %h got no ROB entry", $time, ent.inst);
            errors++;
        end else begin
            compare_rob("o_rob_op", rob_reg, o_rob_op);
            compare_word("o_rob_dest", word_t'(want.rd), o_rob_dest);
        end
        if (want.qj != '0 || want.qk != '0) pending_reads++;
        dispatched++;
        test_issued++;
        issued_rd  = want.rd;
        issued_tag = prev_free_tag;
    endtask

    // Results of the last cycle land first, then a new producer claims its register.
    task automatic update_model();
        if (prev_cdb_valid) begin
            for (int r = 1; r < NUM_REGS; r++) begin
                if (model_tag[r] != '0 && model_tag[r] == prev_cdb_tag) begin
                    model_val[r] = prev_cdb_value;
                    model_tag[r] = '0;
                end
            end
        end
        if (issued_rd != '0) begin
            model_tag[issued_rd] = issued_tag;
            if (issued_tag != '0) in_use[issued_tag] = 1'b1;
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            model_val = '{default: '0};
            model_tag = '{default: '0};
        end else begin
            issued_rd = '0;
            if (o_alu_valid || o_cmp_valid || o_rob_valid) check_dispatch();
            update_model();
        end
        prev_cdb_valid = i_cdb_valid;
        prev_cdb_tag   = i_cdb_tag;
        prev_cdb_value = i_cdb_value;
        prev_free_tag  = i_free_tag;
    end

    // Plays the stations, the ROB tag supply and the execution units.
    task automatic drive_resources();
        tag_t cand;
        tag_t pick;
        int   start;
        i_alu_ready = stress ? ($urandom % 3 != 0) : 1'b1;
        i_cmp_ready = stress ? ($urandom % 3 != 0) : 1'b1;
        pick = '0;
        if (!stress || $urandom % 4 != 0) begin
            for (int k = 0; k < 15; k++) begin
                cand = tag_t'((rot + k) % 15 + 1);
                if (pick == '0 && !in_use[cand] && cand != last_offered) pick = cand;
            end
        end
        if (pick != '0) rot = int'(pick) % 15;
        last_offered = pick;    // It may be taken before its pulse is seen.
        i_free_tag   = pick;
        i_cdb_valid  = 1'b0;
        i_cdb_tag    = '0;
        i_cdb_value  = '0;
        if ($urandom % 2 == 0) begin
            start = int'($urandom % 15);
            for (int k = 0; k < 15; k++) begin
                cand = tag_t'((start + k) % 15 + 1);
                if (in_use[cand] && !i_cdb_valid) begin
                    i_cdb_valid   = 1'b1;
                    i_cdb_tag     = cand;
                    i_cdb_value   = $urandom;
                    in_use[cand]  = 1'b0;
                end
            end
        end
    endtask

    initial begin
        forever begin
            @(posedge clk);
            #2;
            drive_resources();
        end
    end

    // Offers one instruction and returns once the queue has taken it.
    task automatic send_inst(input word_t inst);
        fetch_t ent;
        ent.pc       = next_pc;
        ent.inst     = inst;
        i_inst_valid = 1'b1;
        i_pc         = next_pc;
        i_inst       = inst;
        @(negedge clk);
        while (!o_inst_ready) @(negedge clk);
        fetched.push_back(ent);
        sent++;
        @(posedge clk);
        #2;
        i_inst_valid = 1'b0;
        next_pc      = next_pc + 32'd4;
    endtask

    task automatic run_test(input string name, input int kind, input int count,
                            input logic stress_on);
        int    expected;
        int    start_errors;
        word_t inst;
        expected     = 0;
        start_errors = errors;
        test_issued  = 0;
        stress       = stress_on;
        for (int i = 0; i < count; i++) begin
            inst = gen_inst(kind);
            if (inst[11:7] != '0) expected++;
            else discarded++;
            send_inst(inst);
            if (stress_on && $urandom % 4 == 0) begin
                @(posedge clk);
                #2;
            end
        end
        while (test_issued < expected) @(negedge clk);
        $display("test %s: %0d sent, %0d dispatched, %0d errors",
                 name, count, test_issued, errors - start_errors);
        tests_run++;
        @(posedge clk);
        #2;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Regression failed");
        $finish;
    end

    initial begin : main
        int leftover;
        void'($urandom(SEED));
        rst           = 1'b1;
        i_inst_valid  = 1'b0;
        i_pc          = '0;
        i_inst        = '0;
        i_free_tag    = '0;
        i_cdb_valid   = 1'b0;
        i_cdb_tag     = '0;
        i_cdb_value   = '0;
        i_alu_ready   = 1'b0;
        i_cmp_ready   = 1'b0;
        in_use        = '{default: 1'b0};
        last_offered  = '0;
        rot           = 0;
        stress        = 1'b0;
        next_pc       = 32'h0000_1000;
        errors        = 0;
        sent          = 0;
        dispatched    = 0;
        discarded     = 0;
        pending_reads = 0;
        tests_run     = 0;
        leftover      = 0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        run_test("alu", 0, N_ALU, 1'b0);
        run_test("compare", 1, N_CMP, 1'b0);
        run_test("upper", 2, N_UPPER, 1'b0);
        run_test("depend", 3, N_DEPS, 1'b0);
        run_test("rd_zero", 4, N_RDZERO, 1'b0);
        run_test("stress", 5, N_STRESS, 1'b1);

        repeat (4) @(negedge clk);     // Any stray dispatch shows up here.
        for (int i = 0; i < fetched.size(); i++) begin
            if (fetched[i].inst[11:7] != '0) leftover++;
        end
        if (leftover != 0 || dispatched != sent - discarded) begin
            $display("[ERROR] %0d instructions were never dispatched",
                     sent - discarded - dispatched);
            errors++;
        end
        if (pending_reads == 0) begin
            $display("[ERROR] no dispatch ever read a source that was still pending");
            errors++;
        end
        $write("Summary: %0d tests, %0d sent, %0d dispatched, ", tests_run, sent, dispatched);
        $display("%0d discarded, %0d pending reads, %0d errors",
                 discarded, pending_reads, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: issue_unit.f
logic/issue_pkg.sv
logic/queue_if.sv
logic/operand_if.sv
logic/inst_queue.sv
logic/reg_status.sv
logic/issue_decoder.sv
logic/issue_unit.sv
test/tb_issue_unit.sv

// File: Makefile
# Verilator build and run of the issue unit testbench.

TOP             ?= tb_issue_unit
RTL_TOP         ?= issue_unit
FILELIST        ?= issue_unit.f
OBJ_DIR         ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS      ?= --lint-only -Wall --timing
PASS_TEXT       ?= Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The status of the pipeline is the status of grep, so a missing pass line fails the target.
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "$(PASS_TEXT)" > /dev/null

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
